// File: piece_generator.sv
`timescale 1ns/10ps
`default_nettype none

module piece_generator
  import tetris_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  output logic   req_o,
  input  logic   ack_i,
  output piece_t piece_o
);

  typedef enum logic [1:0] {
    GEN_STEP,     // advance lfsr until a legal piece shows up
    GEN_OFFER,    // req high, waiting for ack
    GEN_RELEASE   // req low, waiting for ack to drop
  } gen_phase_t;

  gen_phase_t  phase_q;
  logic [15:0] lfsr_q;
  logic [15:0] lfsr_next;
  logic        feedback;

  // fibonacci taps 16 14 13 11
  assign feedback  = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  assign lfsr_next = {lfsr_q[14:0], feedback};

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      phase_q <= GEN_STEP;
      lfsr_q  <= LFSR_SEED;
    end else begin
      case (phase_q)
        GEN_STEP: begin
          lfsr_q <= lfsr_next;
          if (lfsr_next[2:0] != 3'd7) begin  // 7 is no piece, step again
            phase_q <= GEN_OFFER;
          end
        end
        GEN_OFFER: begin
          if (ack_i) begin
            phase_q <= GEN_RELEASE;
          end
        end
        GEN_RELEASE: begin
          if (!ack_i) begin
            phase_q <= GEN_STEP;
          end
        end
        default: phase_q <= GEN_STEP;
      endcase
    end
  end

  assign req_o   = (phase_q == GEN_OFFER);
  assign piece_o = piece_t'(lfsr_q[2:0]);  // frozen outside GEN_STEP

  // offered piece must not move until the consumer has taken it
  a_piece_stable: assert property (@(posedge clk) disable iff (rst)
    (req_o && !ack_i) |=> $stable(piece_o));

endmodule

`default_nettype wire

// File: piece_queue.sv
`timescale 1ns/10ps
`default_nettype none

module piece_queue
  import tetris_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  // producer side
  input  logic   in_req_i,
  output logic   in_ack_o,
  input  piece_t in_piece_i,
  // consumer side
  output logic   out_req_o,
  input  logic   out_ack_i,
  output piece_t out_piece_o
);

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_REQ,
    OUT_DONE   // waiting for ack to drop
  } out_phase_t;

  piece_t            mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QCNT_W-1:0] count;
  out_phase_t        out_phase;
  logic              push;
  logic              pop;

  function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] p);
    return (p == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // full queue leaves in_req_i hanging
  assign push = in_req_i && !in_ack_o && (count < QCNT_W'(QUEUE_DEPTH));
  assign pop  = (out_phase == OUT_REQ) && out_ack_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_piece_i;
    end
  end

  //////////////////////////////
  // pointers and handshakes
  //////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_ack_o  <= 1'b0;
      out_phase <= OUT_IDLE;
    end else begin
      if (push) begin
        wr_ptr   <= ptr_inc(wr_ptr);
        in_ack_o <= 1'b1;
      end else if (in_ack_o && !in_req_i) begin
        in_ack_o <= 1'b0;
      end

      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      case (out_phase)
        OUT_IDLE: if (count != '0) out_phase <= OUT_REQ;
        OUT_REQ:  if (out_ack_i) out_phase <= OUT_DONE;
        OUT_DONE: if (!out_ack_i) out_phase <= OUT_IDLE;
        default:  out_phase <= OUT_IDLE;
      endcase
    end
  end

  assign out_req_o   = (out_phase == OUT_REQ);
  assign out_piece_o = mem[rd_ptr];  // oldest entry

  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= QCNT_W'(QUEUE_DEPTH));

  // req and its data stay up until the consumer acks
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    (out_req_o && !out_ack_i) |=> out_req_o && $stable(out_piece_o));

endmodule

`default_nettype wire

// File: project.f
+incdir+.
tetris_pkg.sv
piece_generator.sv
piece_queue.sv
shape_mask.sv
tetris_fsm.sv
tetris_top.sv
tb_tetris.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_tetris -f project.f

sim_out=$(./obj_dir/Vtb_tetris)
echo "$sim_out"

if echo "$sim_out" | grep -q 'All tests passed!'; then
  exit 0
else
  exit 1
fi

// File: shape_mask.sv
`timescale 1ns/10ps
`default_nettype none

module shape_mask
  import tetris_pkg::*;
(
  input  piece_t piece_i,
  input  rot_t   rot_i,
  output mask_t  mask_o
);

  mask_t base;
  mask_t turn1;
  mask_t turn2;
  mask_t turn3;

  // one clockwise quarter turn inside the 4x4 frame
  function automatic mask_t rotate_cw(input mask_t m);
    mask_t turned;
    for (int r = 0; r < 4; r++) begin
      for (int c = 0; c < 4; c++) begin
        turned[4*r + c] = m[4*(3 - c) + r];  // new (r,c) from old (3-c,r)
      end
    end
    return turned;
  endfunction

  assign base  = (piece_i < NUM_PIECES) ? BASE_SHAPES[piece_i] : '0;
  assign turn1 = rotate_cw(base);
  assign turn2 = rotate_cw(turn1);
  assign turn3 = rotate_cw(turn2);

  always_comb begin
    case (rot_i)
      2'd0:    mask_o = base;
      2'd1:    mask_o = turn1;
      2'd2:    mask_o = turn2;
      default: mask_o = turn3;
    endcase
  end

endmodule

`default_nettype wire

// File: tetris_model.svh
`ifndef TETRIS_MODEL_SVH
`define TETRIS_MODEL_SVH

// reference model of the game, included inside the testbench module

logic [15:0] m_gen;    // generator lfsr
grid_t       m_grid;   // row 0 is the top
lines_t      m_lines;
piece_t      m_piece;
int          m_rot;
int          m_row;
int          m_col;    // may go negative for frames with an empty left column

function automatic void reset_model();
  m_gen   = LFSR_SEED;
  m_grid  = '0;
  m_lines = '0;
endfunction

function automatic void clear_board();
  m_grid  = '0;
  m_lines = '0;
endfunction

// next issued piece, 7 never leaves the generator
function automatic piece_t next_issued_piece();
  logic fb;
  do begin
    fb    = m_gen[15] ^ m_gen[13] ^ m_gen[12] ^ m_gen[10];  // taps 16 14 13 11
    m_gen = {m_gen[14:0], fb};
  end while (m_gen[2:0] == 3'd7);
  return piece_t'(m_gen[2:0]);
endfunction

// each set cell at (r,c) moves to (c,3-r) per clockwise turn
function automatic mask_t rotated_mask(input piece_t p, input int rot);
  mask_t m;
  mask_t t;
  m = BASE_SHAPES[p];
  for (int k = 0; k < rot; k++) begin
    t = '0;
    for (int i = 0; i < 16; i++) begin
      if (m[i]) t[4 * (i % 4) + (3 - i / 4)] = 1'b1;
    end
    m = t;
  end
  return m;
endfunction

function automatic bit frame_fits(input int rot, input int row, input int col);
  mask_t m;
  int    r;
  int    c;
  m = rotated_mask(m_piece, rot);
  for (int i = 0; i < 16; i++) begin
    r = row + i / 4;
    c = col + i % 4;
    if (m[i]) begin
      if (r < 0 || r >= GRID_ROWS || c < 0 || c >= GRID_COLS) return 1'b0;
      if (m_grid[r][c] != '0) return 1'b0;
    end
  end
  return 1'b1;
endfunction

// 1 when the new piece fits at the spawn spot
function automatic bit spawn_next();
  m_piece = next_issued_piece();
  m_rot   = 0;
  m_row   = 0;
  m_col   = SPAWN_COL;
  return frame_fits(0, 0, SPAWN_COL);
endfunction

// 1 when a blocked drop calls for a lock
function automatic bit move_piece(input move_t cmd);
  int rot;
  int row;
  int col;
  rot = m_rot;
  row = m_row;
  col = m_col;
  case (cmd)
    LEFT:    col = col - 1;
    RIGHT:   col = col + 1;
    ROR:     rot = (rot + 1) % 4;
    ROL:     rot = (rot + 3) % 4;
    default: row = row + 1;
  endcase
  if (frame_fits(rot, row, col)) begin
    m_rot = rot;
    m_row = row;
    m_col = col;
    return 1'b0;
  end
  return (cmd == DOWN);
endfunction

// writes the piece, then keeps only the rows that are not full, packed at the bottom
function automatic int lock_piece();
  mask_t m;
  grid_t kept;
  int    dst;
  int    cleared;
  bit    full;
  m = rotated_mask(m_piece, m_rot);
  for (int i = 0; i < 16; i++) begin
    if (m[i]) m_grid[m_row + i / 4][m_col + i % 4] = color_t'(m_piece) + color_t'(1);
  end
  kept    = '0;
  dst     = GRID_ROWS - 1;
  cleared = 0;
  for (int r = GRID_ROWS - 1; r >= 0; r--) begin
    full = 1'b1;
    for (int c = 0; c < GRID_COLS; c++) begin
      if (m_grid[r][c] == '0) full = 1'b0;
    end
    if (full) begin
      cleared++;
    end else begin
      kept[dst] = m_grid[r];
      dst--;
    end
  end
  m_grid  = kept;
  m_lines = m_lines + lines_t'(cleared);
  return cleared;
endfunction

`endif

// File: tb_tetris.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tetris
  import tetris_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int NUM_CMDS   = 8000;

  logic        clk;
  logic        rst;
  logic        start;
  logic        cmd_valid;
  move_t       cmd;
  game_state_t state;
  logic        ready;
  logic        game_over;
  grid_t       grid;
  piece_t      piece;
  rot_t        rot;
  row_idx_t    row;
  col_idx_t    col;
  lines_t      lines;

  logic [31:0] rnd_state;
  int          err_piece, err_pos, err_rot, err_grid, err_lines, err_state, err_other;
  int          n_cmds, games, total_cleared;
  bit          in_sync;

  `include "tetris_model.svh"

  tetris_top dut0 (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .state_o     (state),
    .ready_o     (ready),
    .game_over_o (game_over),
    .grid_o      (grid),
    .piece_o     (piece),
    .piece_rot_o (rot),
    .piece_row_o (row),
    .piece_col_o (col),
    .lines_o     (lines)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // random stimulus
  //////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      rnd_state = lfsr_step(rnd_state);
      v = (v << 1) | int'(rnd_state[0]);
    end
    return v;
  endfunction

  function automatic move_t pick_move();
    if (rand_bits(1) == 1) return DOWN;  // half of all commands
    case (rand_bits(2))
      0:       return LEFT;
      1:       return RIGHT;
      2:       return ROR;
      default: return ROL;
    endcase
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_piece(input string name, input piece_t exp, input piece_t act);
    if (exp !== act) begin
      err_piece++;
      $display("ERR %s piece expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_pos(input string name, input row_idx_t exp_row, input col_idx_t exp_col,
                           input row_idx_t act_row, input col_idx_t act_col);
    if (exp_row !== act_row || exp_col !== act_col) begin
      err_pos++;
      $display("ERR %s position expected (%0d,%0d) actual (%0d,%0d)",
               name, exp_row, exp_col, act_row, act_col);
    end
  endtask

  task automatic check_rot(input string name, input rot_t exp, input rot_t act);
    if (exp !== act) begin
      err_rot++;
      $display("ERR %s rotation expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_grid(input string name, input grid_t exp, input grid_t act);
    for (int r = 0; r < GRID_ROWS; r++) begin
      for (int c = 0; c < GRID_COLS; c++) begin
        if (exp[r][c] !== act[r][c]) begin
          err_grid++;
          $display("ERR %s grid[%0d][%0d] expected %0d actual %0d",
                   name, r, c, exp[r][c], act[r][c]);
        end
      end
    end
  endtask

  task automatic check_lines(input string name, input lines_t exp, input lines_t act);
    if (exp !== act) begin
      err_lines++;
      $display("ERR %s lines expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input game_state_t exp, input game_state_t act);
    if (exp !== act) begin
      err_state++;
      $display("ERR %s state expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_all(input string name);
    check_piece(name, m_piece, piece);
    check_pos(name, row_idx_t'(m_row), col_idx_t'(m_col), row, col);
    check_rot(name, rot_t'(m_rot), rot);
    check_grid(name, m_grid, grid);
    check_lines(name, m_lines, lines);
  endtask

  //////////////////////////////
  // sequencing
  //////////////////////////////

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic apply_move(input move_t m);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= m;
    @(posedge clk);  // taken on this edge
    cmd_valid <= 1'b0;
  endtask

  // next spawn ends in play or in game over
  task automatic wait_settled(input bit expect_over, input string name);
    @(negedge clk);
    while (!ready && !game_over) @(negedge clk);
    if (game_over !== expect_over) begin
      err_other++;
      in_sync = 1'b0;
      $display("ERR %s game over expected %0b actual %0b", name, expect_over, game_over);
    end else begin
      check_state(name, expect_over ? GAME_OVER : PLAY, state);
      check_all(name);
    end
  endtask

  initial begin
    bit    expect_over;
    move_t m;
    rst       = 1'b1;
    start     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = LEFT;
    rnd_state = 32'hcae760ca;
    {err_piece, err_pos, err_rot, err_grid, err_lines, err_state, err_other} = '0;
    n_cmds        = 0;
    games         = 0;
    total_cleared = 0;
    in_sync       = 1'b1;
    reset_model();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (ready !== 1'b0 || game_over !== 1'b0) begin
      err_other++;
      $display("ERR reset ready/game over expected 0/0 actual %b/%b", ready, game_over);
    end
    check_state("reset", IDLE, state);
    check_grid("reset", '0, grid);
    check_lines("reset", '0, lines);

    pulse_start();
    expect_over = !spawn_next();
    wait_settled(expect_over, "spawn");
    while (in_sync && n_cmds < NUM_CMDS) begin
      if (expect_over) begin
        pulse_start();
        clear_board();
        expect_over = !spawn_next();
        wait_settled(expect_over, "restart");
      end else begin
        m = pick_move();
        apply_move(m);
        n_cmds++;
        @(negedge clk);
        if (move_piece(m)) begin
          check_state("lock", LOCK, state);
          total_cleared += lock_piece();
          expect_over = !spawn_next();
          if (expect_over) games++;
          wait_settled(expect_over, "lock");
        end else begin
          check_state({"move ", m.name()}, PLAY, state);
          check_all({"move ", m.name()});
        end
      end
    end

    if (in_sync && games == 0) begin
      err_other++;
      $display("no game over was reached within %0d commands", NUM_CMDS);
    end
    $display("%0d commands, %0d games ended, %0d lines cleared", n_cmds, games, total_cleared);
    $display("errors: piece %0d pos %0d rot %0d grid %0d lines %0d state %0d other %0d",
             err_piece, err_pos, err_rot, err_grid, err_lines, err_state, err_other);
    if (err_piece + err_pos + err_rot + err_grid + err_lines + err_state + err_other == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // generous bound per command, covers lock and clear sequences
  initial begin
    #(NUM_CMDS * 200 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the DUT stopped responding", NUM_CMDS * 200);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: tetris_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_fsm
  import tetris_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        start_i,
  input  logic        cmd_valid_i,
  input  move_t       cmd_i,
  input  logic        req_i,
  output logic        ack_o,
  input  piece_t      piece_i,
  output game_state_t state_o,
  output logic        ready_o,
  output logic        game_over_o,
  output grid_t       grid_o,
  output piece_t      piece_o,
  output rot_t        piece_rot_o,
  output row_idx_t    piece_row_o,
  output col_idx_t    piece_col_o,
  output lines_t      lines_o
);

  game_state_t state_q, state_d;
  grid_t       grid_q, grid_d;
  lines_t      lines_q, lines_d;
  piece_t      piece_q;
  rot_t        rot_q, cand_rot;
  row_idx_t    row_q, cand_row;
  col_idx_t    col_q, cand_col;
  mask_t       cur_mask;
  mask_t       cand_mask;
  logic        cand_fits;
  logic        take_cand;
  logic        any_full;
  row_idx_t    full_row;
  color_t      lock_color;

  shape_mask u_cur_shape (.piece_i(piece_q), .rot_i(rot_q), .mask_o(cur_mask));
  shape_mask u_cand_shape (.piece_i(piece_q), .rot_i(cand_rot), .mask_o(cand_mask));

  assign lock_color = color_t'(piece_q + 3'd1);

  //////////////////////////////
  // candidate frame and fit
  //////////////////////////////

  always_comb begin
    cand_rot = rot_q;
    cand_row = row_q;
    cand_col = col_q;
    if (state_q == SPAWN) begin
      cand_rot = '0;
      cand_row = '0;
      cand_col = col_idx_t'(SPAWN_COL);
    end else if (cmd_valid_i) begin
      case (cmd_i)
        LEFT:    cand_col = col_q - 1'b1;  // may wrap, caught by the range test
        RIGHT:   cand_col = col_q + 1'b1;
        ROR:     cand_rot = rot_q + 1'b1;
        ROL:     cand_rot = rot_q - 1'b1;
        DOWN:    cand_row = row_q + 1'b1;
        default: cand_row = row_q;
      endcase
    end
  end

  // every occupied cell inside the well and on an empty cell
  always_comb begin
    row_idx_t cell_row;
    col_idx_t cell_col;
    cand_fits = 1'b1;
    for (int i = 0; i < 16; i++) begin
      cell_row = cand_row + row_idx_t'(i / 4);
      cell_col = cand_col + col_idx_t'(i % 4);
      if (cand_mask[i]) begin
        if (cell_row >= GRID_ROWS || cell_col >= GRID_COLS) begin
          cand_fits = 1'b0;
        end else if (grid_q[cell_row][cell_col] != '0) begin
          cand_fits = 1'b0;
        end
      end
    end
  end

  assign take_cand = (state_q == SPAWN) || (state_q == PLAY && cmd_valid_i && cand_fits);

  // lowest full row wins
  always_comb begin
    logic row_full;
    any_full = 1'b0;
    full_row = '0;
    for (int r = 0; r < GRID_ROWS; r++) begin
      row_full = 1'b1;
      for (int c = 0; c < GRID_COLS; c++) begin
        if (grid_q[r][c] == '0) row_full = 1'b0;
      end
      if (row_full) begin
        any_full = 1'b1;
        full_row = row_idx_t'(r);
      end
    end
  end

  //////////////////////////////
  // grid update
  //////////////////////////////

  always_comb begin
    row_idx_t cell_row;
    col_idx_t cell_col;
    grid_d  = grid_q;
    lines_d = lines_q;
    case (state_q)
      LOCK: begin
        for (int i = 0; i < 16; i++) begin
          cell_row = row_q + row_idx_t'(i / 4);
          cell_col = col_q + col_idx_t'(i % 4);
          if (cur_mask[i] && cell_row < GRID_ROWS && cell_col < GRID_COLS) begin
            grid_d[cell_row][cell_col] = lock_color;
          end
        end
      end
      CLEAR: begin
        if (any_full) begin
          for (int r = 1; r < GRID_ROWS; r++) begin
            if (row_idx_t'(r) <= full_row) grid_d[r] = grid_q[r-1];  // shift down
          end
          grid_d[0] = '0;
          lines_d   = lines_q + 1'b1;
        end
      end
      GAME_OVER: begin
        if (start_i) begin
          grid_d  = '0;
          lines_d = '0;
        end
      end
      default: grid_d = grid_q;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (start_i) state_d = FETCH;
      FETCH:     if (ack_o && !req_i) state_d = SPAWN;  // handshake closed
      SPAWN:     state_d = cand_fits ? PLAY : GAME_OVER;
      PLAY:      if (cmd_valid_i && cmd_i == DOWN && !cand_fits) state_d = LOCK;
      LOCK:      state_d = CLEAR;
      CLEAR:     if (!any_full) state_d = FETCH;
      GAME_OVER: if (start_i) state_d = FETCH;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
      grid_q  <= '0;
      lines_q <= '0;
      ack_o   <= 1'b0;
      piece_q <= '0;
      rot_q   <= '0;
      row_q   <= '0;
      col_q   <= '0;
    end else begin
      state_q <= state_d;
      grid_q  <= grid_d;
      lines_q <= lines_d;
      if (take_cand) begin
        rot_q <= cand_rot;
        row_q <= cand_row;
        col_q <= cand_col;
      end
      if (state_q == FETCH && !ack_o && req_i) begin
        ack_o   <= 1'b1;
        piece_q <= piece_i;
      end else if (ack_o && !req_i) begin
        ack_o <= 1'b0;
      end
    end
  end

  assign state_o     = state_q;
  assign ready_o     = (state_q == PLAY);
  assign game_over_o = (state_q == GAME_OVER);
  assign grid_o      = grid_q;
  assign piece_o     = piece_q;
  assign piece_rot_o = rot_q;
  assign piece_row_o = row_q;
  assign piece_col_o = col_q;
  assign lines_o     = lines_q;

  // ack is only ever up while fetching
  a_ack_fetch: assert property (@(posedge clk) disable iff (rst)
    ack_o |-> state_q == FETCH);

endmodule

`default_nettype wire

// File: tetris_pkg.sv
`default_nettype none

package tetris_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  localparam int GRID_ROWS   = 21;
  localparam int GRID_COLS   = 10;
  localparam int NUM_PIECES  = 7;
  localparam int SPAWN_COL   = 3;   // left edge of the spawn frame

  // piece queue
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

  localparam logic [15:0] LFSR_SEED = 16'hace1;  // must be nonzero

  //////////////////////////////
  // types
  //////////////////////////////

  typedef logic [2:0]  piece_t;    // I O T S Z J L = 0..6
  typedef logic [2:0]  color_t;    // 0 empty, else piece + 1
  typedef logic [1:0]  rot_t;      // clockwise quarter turns
  typedef logic [4:0]  row_idx_t;
  typedef logic [3:0]  col_idx_t;
  typedef logic [15:0] mask_t;     // bit 4*r + c
  typedef logic [15:0] lines_t;

  // row 0 is the top of the well
  typedef color_t [GRID_ROWS-1:0][GRID_COLS-1:0] grid_t;

  typedef enum logic [2:0] {
    LEFT,
    RIGHT,
    ROR,
    ROL,
    DOWN
  } move_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    SPAWN,
    PLAY,
    LOCK,
    CLEAR,
    GAME_OVER
  } game_state_t;

  //////////////////////////////
  // shapes at rotation 0
  //////////////////////////////

  localparam mask_t BASE_SHAPES [NUM_PIECES] = '{
    16'h00f0,  // I, flat in frame row 1
    16'h0066,  // O
    16'h0072,  // T
    16'h0036,  // S
    16'h0063,  // Z
    16'h0071,  // J
    16'h0074   // L
  };

endpackage

`default_nettype wire

// File: tetris_top.sv
`timescale 1ns/10ps
`default_nettype none

module tetris_top
  import tetris_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        start_i,
  input  logic        cmd_valid_i,
  input  move_t       cmd_i,
  output game_state_t state_o,
  output logic        ready_o,
  output logic        game_over_o,
  output grid_t       grid_o,
  output piece_t      piece_o,
  output rot_t        piece_rot_o,
  output row_idx_t    piece_row_o,
  output col_idx_t    piece_col_o,
  output lines_t      lines_o
);

  // generator to queue
  logic   gen_req;
  logic   gen_ack;
  piece_t gen_piece;

  // queue to controller
  logic   q_req;
  logic   q_ack;
  piece_t q_piece;

  piece_generator u_generator (
    .clk     (clk),
    .rst     (rst),
    .req_o   (gen_req),
    .ack_i   (gen_ack),
    .piece_o (gen_piece)
  );

  piece_queue u_queue (
    .clk         (clk),
    .rst         (rst),
    .in_req_i    (gen_req),
    .in_ack_o    (gen_ack),
    .in_piece_i  (gen_piece),
    .out_req_o   (q_req),
    .out_ack_i   (q_ack),
    .out_piece_o (q_piece)
  );

  tetris_fsm u_fsm (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .req_i       (q_req),
    .ack_o       (q_ack),
    .piece_i     (q_piece),
    .state_o     (state_o),
    .ready_o     (ready_o),
    .game_over_o (game_over_o),
    .grid_o      (grid_o),
    .piece_o     (piece_o),
    .piece_rot_o (piece_rot_o),
    .piece_row_o (piece_row_o),
    .piece_col_o (piece_col_o),
    .lines_o     (lines_o)
  );

endmodule

`default_nettype wire
